// ==== include/riscvDefs.svh ====
// Opcode, nop and reset-PC constants for the RV32 datapath
// Pulled into the RTL package and into the testbench with `include
`ifndef riscvDefsSvh
`define riscvDefsSvh

// Control-flow opcodes
`define opBranch 7'b1100011
`define opJal    7'b1101111
`define opJalr   7'b1100111

// addi x0, x0, 0
`define nopInstr 32'h0000_0013

// PC after reset
`define pcStart  32'h0000_0000

`endif

// ==== design/rvPkg.sv ====
// Widths, control encodings and stage-boundary types of the RV32 datapath
// Design files refer to these by scoped name
package rvPkg;

`include "riscvDefs.svh"

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int numRegs  = 32;

    typedef logic [regAddrW-1:0] addrT;
    typedef logic [xlen-1:0]     wordT;

    localparam wordT resetPc = `pcStart;
    localparam wordT nopWord = `nopInstr;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluXor = 3'b100,
        aluSlt = 3'b101
    } aluOpT;

    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    typedef enum logic [1:0] {
        resMem     = 2'b00,
        resAlu     = 2'b01,
        resPcPlus4 = 2'b10,
        resImm     = 2'b11
    } resultSrcT;

    // One instruction word, read as R-type fields or as a U-type word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            addrT       rs2;
            addrT       rs1;
            logic [2:0] funct3;
            addrT       rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [19:0] upperImm;
            addrT        rd;
            logic [6:0]  opcode;
        } uView;
    } instrU;

    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        logic       funct7b5;
        addrT       rs1;
        addrT       rs2;
        addrT       rd;
    } decodeFieldsT;

    typedef struct packed {
        logic   stallF;
        logic   stallD;
        logic   flushD;
        logic   flushE;
        fwdSelT forwardA;
        fwdSelT forwardB;
    } hazardCtrlT;

    typedef struct packed {
        wordT rd1;
        wordT rd2;
        wordT pc;
        wordT pcPlus4;
        wordT imm;
        addrT rs1;
        addrT rs2;
        addrT rd;
    } idExT;

    typedef struct packed {
        wordT aluResult;
        wordT writeData;
        wordT imm;
        wordT pcPlus4;
        addrT rd;
    } exMemT;

endpackage

// ==== design/aluUnit.sv ====
// Integer ALU for the execute stage with zero flag for branch compare
`timescale 1ns/1ps

module aluUnit (
    input  rvPkg::wordT  a_i,
    input  rvPkg::wordT  b_i,
    input  rvPkg::aluOpT op_i,
    output rvPkg::wordT  result_o,
    output logic         zero_o
);

    always_comb begin
        case (op_i)
            rvPkg::aluAdd: result_o = a_i + b_i;
            rvPkg::aluSub: result_o = a_i - b_i;
            rvPkg::aluAnd: result_o = a_i & b_i;
            rvPkg::aluOr:  result_o = a_i | b_i;
            rvPkg::aluXor: result_o = a_i ^ b_i;
            // Signed less-than as a zero-extended word
            rvPkg::aluSlt: result_o = rvPkg::wordT'($signed(a_i) < $signed(b_i));
            default:       result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == '0);

    // A subtract gives zero exactly when the operands match
    always_comb begin
        zeroOnEqualSub: assert #0 ((op_i != rvPkg::aluSub) || (zero_o == (a_i == b_i)))
            else $error("zero flag disagrees with operand compare on subtract");
    end

endmodule

// ==== design/regFile.sv ====
// 32 x 32 integer register file, two read ports and one write port
// Reads of the register being written return the new value in the same cycle
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  rvPkg::addrT rs1_i,
    input  rvPkg::addrT rs2_i,
    input  rvPkg::addrT rd_i,
    input  logic        we_i,
    input  rvPkg::wordT wd_i,
    output rvPkg::wordT rd1_o,
    output rvPkg::wordT rd2_o
);

    rvPkg::wordT regs [rvPkg::numRegs];

    // x0 never takes a write
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Write-through bypass with x0 hardwired
    always_comb begin
        if (rs1_i == '0)
            rd1_o = '0;
        else if (we_i && (rd_i == rs1_i))
            rd1_o = wd_i;
        else
            rd1_o = regs[rs1_i];

        if (rs2_i == '0)
            rd2_o = '0;
        else if (we_i && (rd_i == rs2_i))
            rd2_o = wd_i;
        else
            rd2_o = regs[rs2_i];
    end

    // A stored word shows on the read port in the following cycle
    writeReadsBack: assert property (
        @(posedge clk) disable iff (reset)
        (we_i && (rd_i != '0)) |=>
            (rs1_i != $past(rd_i)) || (we_i && (rd_i == rs1_i)) || (rd1_o == $past(wd_i))
    ) else $error("register read missed the previous write");

endmodule

// ==== design/fetchStage.sv ====
// Fetch stage: PC register with stall and branch redirect, and the IF/ID register
`timescale 1ns/1ps

module fetchStage (
    input  logic              clk,
    input  logic              reset,
    input  rvPkg::hazardCtrlT hazardCtrl_i,
    input  logic              pcSrcE_i,
    input  rvPkg::wordT       pcTargetE_i,
    input  rvPkg::wordT       instrF_i,
    output rvPkg::wordT       pcF_o,
    output rvPkg::instrU      instrD_o,
    output rvPkg::wordT       pcD_o,
    output rvPkg::wordT       pcPlus4D_o
);

    rvPkg::wordT pcPlus4F;

    assign pcPlus4F = pcF_o + 32'd4;

    // Redirect wins over a fetch stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= rvPkg::resetPc;
        end else if (pcSrcE_i) begin
            pcF_o <= pcTargetE_i;
        end else if (!hazardCtrl_i.stallF) begin
            pcF_o <= pcPlus4F;
        end
    end

    // Flushed decode sees a nop
    always_ff @(posedge clk) begin
        if (reset || hazardCtrl_i.flushD) begin
            instrD_o   <= rvPkg::instrU'(rvPkg::nopWord);
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (!hazardCtrl_i.stallD) begin
            instrD_o   <= rvPkg::instrU'(instrF_i);
            pcD_o      <= pcF_o;
            pcPlus4D_o <= pcPlus4F;
        end
    end

    redirectLandsOnTarget: assert property (
        @(posedge clk) disable iff (reset)
        pcSrcE_i |=> (pcF_o == $past(pcTargetE_i))
    ) else $error("PC missed branch target after redirect");

endmodule

// ==== design/decodeStage.sv ====
// Decode stage: field extraction, immediate extension, register file read
// and the ID/EX register, cleared on flushE
`timescale 1ns/1ps

module decodeStage (
    input  logic                clk,
    input  logic                reset,
    input  rvPkg::instrU        instrD_i,
    input  rvPkg::wordT         pcD_i,
    input  rvPkg::wordT         pcPlus4D_i,
    input  rvPkg::immSrcT       immSrcD_i,
    input  logic                flushE_i,
    input  logic                regWriteW_i,
    input  rvPkg::addrT         rdW_i,
    input  rvPkg::wordT         resultW_i,
    output rvPkg::decodeFieldsT fields_o,
    output rvPkg::idExT         idEx_o
);

    rvPkg::wordT rd1D;
    rvPkg::wordT rd2D;
    rvPkg::wordT immD;
    logic        signBit;
    rvPkg::idExT idExD;

    assign fields_o.op       = instrD_i.rView.opcode;
    assign fields_o.funct3   = instrD_i.rView.funct3;
    assign fields_o.funct7b5 = instrD_i.rView.funct7[5];
    assign fields_o.rs1      = instrD_i.rView.rs1;
    assign fields_o.rs2      = instrD_i.rView.rs2;
    assign fields_o.rd       = instrD_i.rView.rd;

    assign signBit = instrD_i.rView.funct7[6];

    // Immediates rebuilt from the R-type field slices
    always_comb begin
        case (immSrcD_i)
            rvPkg::immI: immD = {{20{signBit}}, instrD_i.rView.funct7, instrD_i.rView.rs2};
            rvPkg::immS: immD = {{20{signBit}}, instrD_i.rView.funct7, instrD_i.rView.rd};
            rvPkg::immB: immD = {{20{signBit}}, instrD_i.rView.rd[0],
                                 instrD_i.rView.funct7[5:0], instrD_i.rView.rd[4:1], 1'b0};
            rvPkg::immJ: immD = {{12{signBit}}, instrD_i.rView.rs1, instrD_i.rView.funct3,
                                 instrD_i.rView.rs2[0], instrD_i.rView.funct7[5:0],
                                 instrD_i.rView.rs2[4:1], 1'b0};
            rvPkg::immU: immD = {instrD_i.uView.upperImm, 12'b0};
            default:     immD = '0;
        endcase
    end

    regFile regFile_i (
        .clk   (clk),
        .reset (reset),
        .rs1_i (instrD_i.rView.rs1),
        .rs2_i (instrD_i.rView.rs2),
        .rd_i  (rdW_i),
        .we_i  (regWriteW_i),
        .wd_i  (resultW_i),
        .rd1_o (rd1D),
        .rd2_o (rd2D)
    );

    always_comb begin
        idExD.rd1     = rd1D;
        idExD.rd2     = rd2D;
        idExD.pc      = pcD_i;
        idExD.pcPlus4 = pcPlus4D_i;
        idExD.imm     = immD;
        idExD.rs1     = instrD_i.rView.rs1;
        idExD.rs2     = instrD_i.rView.rs2;
        idExD.rd      = instrD_i.rView.rd;
    end

    // A flush turns the slot into a bubble writing x0
    always_ff @(posedge clk) begin
        if (reset || flushE_i)
            idEx_o <= '0;
        else
            idEx_o <= idExD;
    end

endmodule

// ==== design/executeStage.sv ====
// Execute stage: operand forwarding, ALU, branch target adder and the EX/MEM register
`timescale 1ns/1ps

module executeStage (
    input  logic          clk,
    input  logic          reset,
    input  rvPkg::idExT   idEx_i,
    input  rvPkg::fwdSelT forwardA_i,
    input  rvPkg::fwdSelT forwardB_i,
    input  rvPkg::wordT   forwardDataM_i,
    input  rvPkg::wordT   resultW_i,
    input  logic          aluSrcE_i,
    input  rvPkg::aluOpT  aluControlE_i,
    output rvPkg::wordT   pcTargetE_o,
    output logic          zeroE_o,
    output rvPkg::exMemT  exMem_o
);

    rvPkg::wordT  srcA;
    rvPkg::wordT  writeDataE;
    rvPkg::wordT  srcB;
    rvPkg::wordT  aluResultE;
    rvPkg::exMemT exMemE;

    // Same three-way choice for both operands
    function automatic rvPkg::wordT fwdMux(
        input rvPkg::fwdSelT sel,
        input rvPkg::wordT   regVal,
        input rvPkg::wordT   wbVal,
        input rvPkg::wordT   memVal
    );
        case (sel)
            rvPkg::fwdWb:  return wbVal;
            rvPkg::fwdMem: return memVal;
            default:       return regVal;
        endcase
    endfunction

    assign srcA       = fwdMux(forwardA_i, idEx_i.rd1, resultW_i, forwardDataM_i);
    assign writeDataE = fwdMux(forwardB_i, idEx_i.rd2, resultW_i, forwardDataM_i);

    // aluSrc high selects the immediate
    assign srcB = aluSrcE_i ? idEx_i.imm : writeDataE;

    aluUnit aluUnit_i (
        .a_i      (srcA),
        .b_i      (srcB),
        .op_i     (aluControlE_i),
        .result_o (aluResultE),
        .zero_o   (zeroE_o)
    );

    // Branch and jal target
    assign pcTargetE_o = idEx_i.pc + idEx_i.imm;

    always_comb begin
        exMemE.aluResult = aluResultE;
        exMemE.writeData = writeDataE;
        exMemE.imm       = idEx_i.imm;
        exMemE.pcPlus4   = idEx_i.pcPlus4;
        exMemE.rd        = idEx_i.rd;
    end

    always_ff @(posedge clk) begin
        if (reset)
            exMem_o <= '0;
        else
            exMem_o <= exMemE;
    end

endmodule

// ==== design/memWbStage.sv ====
// Memory and writeback stages: forward-value mux, MEM/WB register and result mux
// The memory-stage value feeds the execute forwarding path
`timescale 1ns/1ps

module memWbStage (
    input  logic             clk,
    input  logic             reset,
    input  rvPkg::exMemT     exMem_i,
    input  rvPkg::resultSrcT resultSrcM_i,
    input  rvPkg::resultSrcT resultSrcW_i,
    input  rvPkg::wordT      readDataM_i,
    output rvPkg::wordT      forwardDataM_o,
    output rvPkg::wordT      resultW_o,
    output rvPkg::addrT      rdW_o
);

    rvPkg::wordT aluResultW;
    rvPkg::wordT readDataW;
    rvPkg::wordT immW;
    rvPkg::wordT pcPlus4W;

    // Load data is not ready here, so a load forwards the address
    always_comb begin
        case (resultSrcM_i)
            rvPkg::resPcPlus4: forwardDataM_o = exMem_i.pcPlus4;
            rvPkg::resImm:     forwardDataM_o = exMem_i.imm;
            default:           forwardDataM_o = exMem_i.aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultW <= '0;
            readDataW  <= '0;
            immW       <= '0;
            pcPlus4W   <= '0;
            rdW_o      <= '0;
        end else begin
            aluResultW <= exMem_i.aluResult;
            readDataW  <= readDataM_i;
            immW       <= exMem_i.imm;
            pcPlus4W   <= exMem_i.pcPlus4;
            rdW_o      <= exMem_i.rd;
        end
    end

    always_comb begin
        case (resultSrcW_i)
            rvPkg::resMem:     resultW_o = readDataW;
            rvPkg::resAlu:     resultW_o = aluResultW;
            rvPkg::resPcPlus4: resultW_o = pcPlus4W;
            rvPkg::resImm:     resultW_o = immW;
            default:           resultW_o = aluResultW;
        endcase
    end

endmodule

// ==== design/pipelineDatapath.sv ====
// Top of the five-stage RV32 datapath
// Controller, hazard unit and both memories sit outside and drive the strobes
`timescale 1ns/1ps

module pipelineDatapath (
    input  logic                clk,
    input  logic                reset,
    input  rvPkg::wordT         instrF_i,
    input  rvPkg::hazardCtrlT   hazardCtrl_i,
    input  rvPkg::immSrcT       immSrcD_i,
    input  logic                aluSrcE_i,
    input  rvPkg::aluOpT        aluControlE_i,
    input  logic                pcSrcE_i,
    input  rvPkg::resultSrcT    resultSrcM_i,
    input  rvPkg::resultSrcT    resultSrcW_i,
    input  logic                regWriteW_i,
    input  rvPkg::wordT         readDataM_i,
    output rvPkg::wordT         pcF_o,
    output rvPkg::decodeFieldsT decodeFields_o,
    output rvPkg::addrT         rs1E_o,
    output rvPkg::addrT         rs2E_o,
    output rvPkg::addrT         rdE_o,
    output rvPkg::addrT         rdM_o,
    output rvPkg::addrT         rdW_o,
    output logic                zeroE_o,
    output rvPkg::wordT         aluResultM_o,
    output rvPkg::wordT         writeDataM_o
);

    rvPkg::instrU instrD;
    rvPkg::wordT  pcD;
    rvPkg::wordT  pcPlus4D;
    rvPkg::idExT  idExE;
    rvPkg::exMemT exMemM;
    rvPkg::wordT  pcTargetE;
    rvPkg::wordT  forwardDataM;
    rvPkg::wordT  resultW;

    fetchStage fetchStage_i (
        .clk          (clk),
        .reset        (reset),
        .hazardCtrl_i (hazardCtrl_i),
        .pcSrcE_i     (pcSrcE_i),
        .pcTargetE_i  (pcTargetE),
        .instrF_i     (instrF_i),
        .pcF_o        (pcF_o),
        .instrD_o     (instrD),
        .pcD_o        (pcD),
        .pcPlus4D_o   (pcPlus4D)
    );

    decodeStage decodeStage_i (
        .clk         (clk),
        .reset       (reset),
        .instrD_i    (instrD),
        .pcD_i       (pcD),
        .pcPlus4D_i  (pcPlus4D),
        .immSrcD_i   (immSrcD_i),
        .flushE_i    (hazardCtrl_i.flushE),
        .regWriteW_i (regWriteW_i),
        .rdW_i       (rdW_o),
        .resultW_i   (resultW),
        .fields_o    (decodeFields_o),
        .idEx_o      (idExE)
    );

    executeStage executeStage_i (
        .clk            (clk),
        .reset          (reset),
        .idEx_i         (idExE),
        .forwardA_i     (hazardCtrl_i.forwardA),
        .forwardB_i     (hazardCtrl_i.forwardB),
        .forwardDataM_i (forwardDataM),
        .resultW_i      (resultW),
        .aluSrcE_i      (aluSrcE_i),
        .aluControlE_i  (aluControlE_i),
        .pcTargetE_o    (pcTargetE),
        .zeroE_o        (zeroE_o),
        .exMem_o        (exMemM)
    );

    memWbStage memWbStage_i (
        .clk            (clk),
        .reset          (reset),
        .exMem_i        (exMemM),
        .resultSrcM_i   (resultSrcM_i),
        .resultSrcW_i   (resultSrcW_i),
        .readDataM_i    (readDataM_i),
        .forwardDataM_o (forwardDataM),
        .resultW_o      (resultW),
        .rdW_o          (rdW_o)
    );

    // Register indices seen by the hazard unit
    assign rs1E_o = idExE.rs1;
    assign rs2E_o = idExE.rs2;
    assign rdE_o  = idExE.rd;
    assign rdM_o  = exMemM.rd;

    // Data memory address and store data
    assign aluResultM_o = exMemM.aluResult;
    assign writeDataM_o = exMemM.writeData;

endmodule

// ==== test/tbPipelineDatapath.sv ====
// Directed testbench for the five-stage RV32 datapath
// Plays controller, hazard unit and both memories, driving on the falling edge
`timescale 1ns/1ps

`include "riscvDefs.svh"

module tbPipelineDatapath;

    localparam int clkPeriod = 20;
    // Reset, fetch walk, 11 serial instructions of 5 cycles, forwarding and flushes
    localparam int budgetCycles = 2 * (4 + 8 + 11 * 5 + 12 + 8);

    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opReg   = 7'b0110011;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opLui   = 7'b0110111;

    logic                clk;
    logic                reset;
    rvPkg::wordT         instrF;
    rvPkg::hazardCtrlT   hazard;
    rvPkg::immSrcT       immSrcD;
    logic                aluSrcE;
    rvPkg::aluOpT        aluControlE;
    logic                pcSrcE;
    rvPkg::resultSrcT    resultSrcM;
    rvPkg::resultSrcT    resultSrcW;
    logic                regWriteW;
    rvPkg::wordT         readDataM;
    rvPkg::wordT         pcF_o;
    rvPkg::decodeFieldsT decodeFields_o;
    rvPkg::addrT         rs1E_o;
    rvPkg::addrT         rs2E_o;
    rvPkg::addrT         rdE_o;
    rvPkg::addrT         rdM_o;
    rvPkg::addrT         rdW_o;
    logic                zeroE_o;
    rvPkg::wordT         aluResultM_o;
    rvPkg::wordT         writeDataM_o;

    integer      seed = 32'h16ad_d6ef;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] opA;
    logic [31:0] opB;
    // Snapshots taken while an instruction walks the pipe
    logic [31:0] pcSeen;
    logic [31:0] pcAfter;
    logic [31:0] aluSeen;
    logic [31:0] storeSeen;
    logic        zeroSeen;

    pipelineDatapath dut_i (
        .clk            (clk),
        .reset          (reset),
        .instrF_i       (instrF),
        .hazardCtrl_i   (hazard),
        .immSrcD_i      (immSrcD),
        .aluSrcE_i      (aluSrcE),
        .aluControlE_i  (aluControlE),
        .pcSrcE_i       (pcSrcE),
        .resultSrcM_i   (resultSrcM),
        .resultSrcW_i   (resultSrcW),
        .regWriteW_i    (regWriteW),
        .readDataM_i    (readDataM),
        .pcF_o          (pcF_o),
        .decodeFields_o (decodeFields_o),
        .rs1E_o         (rs1E_o),
        .rs2E_o         (rs2E_o),
        .rdE_o          (rdE_o),
        .rdM_o          (rdM_o),
        .rdW_o          (rdW_o),
        .zeroE_o        (zeroE_o),
        .aluResultM_o   (aluResultM_o),
        .writeDataM_o   (writeDataM_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] nextRand();
        nextRand = $random(seed);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    // Instruction encoders
    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {7'b0, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `opBranch};
    endfunction

    task automatic tick();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic driveIdle();
        instrF      = `nopInstr;
        hazard      = '0;
        immSrcD     = rvPkg::immI;
        aluSrcE     = 1'b0;
        aluControlE = rvPkg::aluAdd;
        pcSrcE      = 1'b0;
        resultSrcM  = rvPkg::resAlu;
        resultSrcW  = rvPkg::resAlu;
        regWriteW   = 1'b0;
        readDataM   = '0;
    endtask

    // Walks one instruction through D, E, M and W with nops around it
    task automatic runInstr(input logic [31:0] instr, input rvPkg::immSrcT immSrc,
                            input logic aluSrc, input rvPkg::aluOpT aluOp,
                            input rvPkg::resultSrcT resSrc, input logic regWrite,
                            input logic [31:0] memData, input logic branch);
        pcSeen = pcF_o;
        instrF = instr;
        tick();
        instrF  = `nopInstr;
        immSrcD = immSrc;
        tick();
        immSrcD     = rvPkg::immI;
        aluSrcE     = aluSrc;
        aluControlE = aluOp;
        pcSrcE      = branch;
        #(clkPeriod / 4);
        zeroSeen = zeroE_o;
        tick();
        pcSrcE     = 1'b0;
        pcAfter    = pcF_o;
        aluSeen    = aluResultM_o;
        storeSeen  = writeDataM_o;
        resultSrcM = resSrc;
        readDataM  = memData;
        tick();
        resultSrcM = rvPkg::resAlu;
        readDataM  = '0;
        resultSrcW = resSrc;
        regWriteW  = regWrite;
        tick();
        driveIdle();
    endtask

    // A load whose memory data is the wanted value
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
        runInstr(encI(12'd0, 5'd0, 3'b010, rd, opLoad), rvPkg::immI, 1'b1, rvPkg::aluAdd,
                 rvPkg::resMem, 1'b1, value, 1'b0);
    endtask

    task automatic testFetch();
        logic [31:0] expPc;
        expPc = `pcStart;
        checkVal("pcF_o", pcF_o, expPc);
        repeat (3) begin
            tick();
            expPc = expPc + 32'd4;
            checkVal("pcF_o", pcF_o, expPc);
        end
        hazard.stallF = 1'b1;
        repeat (2) begin
            tick();
            checkVal("pcF_o", pcF_o, expPc);
        end
        hazard.stallF = 1'b0;
    endtask

    task automatic testAluWriteback();
        logic [31:0] rnd;
        logic [11:0] imm;
        opA = nextRand();
        opB = nextRand();
        loadReg(5'd1, opA);
        loadReg(5'd2, opB);
        rnd = nextRand();
        imm = rnd[11:0];
        runInstr(encI(imm, 5'd1, 3'b000, 5'd3, opImm), rvPkg::immI, 1'b1, rvPkg::aluAdd,
                 rvPkg::resAlu, 1'b1, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, opA + sext12(imm));
        runInstr(encR(5'd2, 5'd1, 3'b010, 5'd4), rvPkg::immI, 1'b0, rvPkg::aluSlt,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
        runInstr(encR(5'd2, 5'd1, 3'b100, 5'd5), rvPkg::immI, 1'b0, rvPkg::aluXor,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, opA ^ opB);
        // x3 came back through writeback
        runInstr(encI(12'd0, 5'd3, 3'b000, 5'd6, opImm), rvPkg::immI, 1'b1, rvPkg::aluAdd,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, opA + sext12(imm));
    endtask

    task automatic testForwarding();
        // x7 is never written, so only a forward gives the right sum
        instrF = encR(5'd2, 5'd1, 3'b000, 5'd7);
        tick();
        instrF = encR(5'd1, 5'd7, 3'b000, 5'd8);
        tick();
        // First add now in execute
        checkVal("rs1E_o", {27'b0, rs1E_o}, 32'd1);
        checkVal("rs2E_o", {27'b0, rs2E_o}, 32'd2);
        instrF = `nopInstr;
        tick();
        resultSrcM      = rvPkg::resAlu;
        hazard.forwardA = rvPkg::fwdMem;
        checkVal("rdM_o", {27'b0, rdM_o}, 32'd7);
        checkVal("aluResultM_o", aluResultM_o, opA + opB);
        tick();
        hazard.forwardA = rvPkg::fwdReg;
        checkVal("rdW_o", {27'b0, rdW_o}, 32'd7);
        checkVal("aluResultM_o", aluResultM_o, opA + opB + opA);

        // One bubble apart, the value comes from writeback
        instrF = encR(5'd2, 5'd1, 3'b000, 5'd7);
        tick();
        instrF = `nopInstr;
        tick();
        instrF = encR(5'd2, 5'd7, 3'b000, 5'd9);
        tick();
        instrF = `nopInstr;
        tick();
        resultSrcW      = rvPkg::resAlu;
        hazard.forwardA = rvPkg::fwdWb;
        tick();
        hazard.forwardA = rvPkg::fwdReg;
        checkVal("aluResultM_o", aluResultM_o, opA + opB + opB);
    endtask

    task automatic testStoreUpper();
        logic [31:0] rnd;
        logic [11:0] imm;
        rnd = nextRand();
        imm = rnd[11:0];
        runInstr(encS(imm, 5'd2, 5'd1), rvPkg::immS, 1'b1, rvPkg::aluAdd,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, opA + sext12(imm));
        checkVal("writeDataM_o", storeSeen, opB);
        runInstr({rnd[31:12], 5'd10, opLui}, rvPkg::immU, 1'b1, rvPkg::aluAdd,
                 rvPkg::resImm, 1'b1, '0, 1'b0);
        runInstr(encI(12'd0, 5'd10, 3'b000, 5'd11, opImm), rvPkg::immI, 1'b1, rvPkg::aluAdd,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("aluResultM_o", aluSeen, {rnd[31:12], 12'b0});
    endtask

    task automatic testBranch();
        logic [31:0] rnd;
        logic [12:0] offset;
        rnd    = nextRand();
        offset = {rnd[12:1], 1'b0};
        runInstr(encB(offset, 5'd1, 5'd1), rvPkg::immB, 1'b0, rvPkg::aluSub,
                 rvPkg::resAlu, 1'b0, '0, 1'b1);
        checkVal("zeroE_o", {31'b0, zeroSeen}, 32'd1);
        checkVal("pcF_o", pcAfter, pcSeen + sext13(offset));
        runInstr(encB(offset, 5'd2, 5'd1), rvPkg::immB, 1'b0, rvPkg::aluSub,
                 rvPkg::resAlu, 1'b0, '0, 1'b0);
        checkVal("zeroE_o", {31'b0, zeroSeen}, {31'b0, opA == opB});
    endtask

    task automatic testFlush();
        logic [31:0]         nop;
        rvPkg::decodeFieldsT expFields;
        nop       = `nopInstr;
        expFields = {nop[6:0], nop[14:12], nop[30], nop[19:15], nop[24:20], nop[11:7]};
        instrF        = encR(5'd2, 5'd1, 3'b000, 5'd7);
        hazard.flushD = 1'b1;
        tick();
        hazard.flushD = 1'b0;
        instrF        = `nopInstr;
        checkVal("decodeFields_o", {6'b0, decodeFields_o}, {6'b0, expFields});

        // Unflushed, rd reaches execute
        instrF = encR(5'd2, 5'd1, 3'b000, 5'd7);
        tick();
        instrF = `nopInstr;
        tick();
        checkVal("rdE_o", {27'b0, rdE_o}, 32'd7);
        instrF = encR(5'd2, 5'd1, 3'b000, 5'd7);
        tick();
        instrF        = `nopInstr;
        hazard.flushE = 1'b1;
        tick();
        hazard.flushE = 1'b0;
        checkVal("rdE_o", {27'b0, rdE_o}, 32'd0);
    endtask

    initial begin
        driveIdle();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        testFetch();
        testAluWriteback();
        testForwarding();
        testStoreUpper();
        testBranch();
        testFlush();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(budgetCycles * clkPeriod);
        $display("Timeout: tests did not finish within %0d cycles", budgetCycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
design/rvPkg.sv
design/aluUnit.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/pipelineDatapath.sv
test/tbPipelineDatapath.sv

// ==== Bender.yml ====
package:
  name: pipeline_datapath

sources:
  - include_dirs:
      - include
    files:
      - design/rvPkg.sv
      - design/aluUnit.sv
      - design/regFile.sv
      - design/fetchStage.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/memWbStage.sv
      - design/pipelineDatapath.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tbPipelineDatapath.sv
